// ==== source/hinfPkg.sv ====
// shared Q.35 fixed-point types, frame constants and product rescaling for the canceller
package hinfPkg;

  //////////////////////////////////////////////////
  // number format
  //////////////////////////////////////////////////
  localparam int fracBits = 35; // Q.35

  typedef logic signed [63:0]  sampleT;  // samples, weights, gains
  typedef logic signed [127:0] productT; // raw product of two samples

  localparam sampleT fixOne = sampleT'(64'sd1 <<< fracBits);

  //////////////////////////////////////////////////
  // frame layout
  //////////////////////////////////////////////////
  localparam int numEeg   = 5; // eeg channels first
  localparam int numRef   = 3; // eog1-eog3, eog3-eog2, one
  localparam int frameLen = 8; // words per frame

  // sign bit plus bits 98:35, kept to 64 bits, so the sign bit falls off the top
  function automatic sampleT rescale(input productT p);
    logic [64:0] wide;
    wide = {p[127], p[fracBits+63:fracBits]};
    return sampleT'(wide[63:0]);
  endfunction

endpackage

// ==== source/frameReader.sv ====
// pulls one eight-word frame from the receive FIFO and presents it as channel registers
`timescale 1ns/100ps

module frameReader import hinfPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rxEmpty,
  input  sampleT din,
  output logic   rd,
  input  logic   estReady,
  output logic   frameVld,
  output sampleT eegIn [numEeg],
  output sampleT eogIn [numRef]
);

  logic [3:0] rdCnt;  // reads issued this frame
  logic [3:0] rxCnt;  // words landed this frame
  logic       rdPend; // popped word is on din now
  sampleT     words [frameLen];

  // a new frame starts only when the estimator can take it
  assign rd = !rxEmpty && (rdCnt < 4'(frameLen)) && ((rdCnt != 4'd0) || estReady);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdCnt    <= '0;
      rxCnt    <= '0;
      rdPend   <= 1'b0;
      frameVld <= 1'b0;
    end else begin
      rdPend   <= rd;
      frameVld <= rdPend && (rxCnt == 4'(frameLen - 1)); // eighth word landing
      if (frameVld) begin
        rdCnt <= '0;
        rxCnt <= '0;
      end else begin
        if (rd)
          rdCnt <= rdCnt + 4'd1;
        if (rdPend)
          rxCnt <= rxCnt + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdPend)
      words[rxCnt[2:0]] <= din; // arrival order = channel order
  end

  always_comb begin
    for (int j = 0; j < numEeg; j++)
      eegIn[j] = words[j];
    for (int k = 0; k < numRef; k++)
      eogIn[k] = words[numEeg + k];
  end

endmodule

// ==== source/artifactEstimator.sv ====
// builds the EOG reference vector, estimates the artifact per channel and subtracts it
`timescale 1ns/100ps

module artifactEstimator import hinfPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   frameVld,
  input  sampleT eegIn [numEeg],
  input  sampleT eogIn [numRef],
  input  sampleT weights [numRef][numEeg],
  input  logic   wUpdated,
  input  logic   writerBusy,
  output logic   estReady,
  output logic   estVld,
  output sampleT refVec [numRef],
  output sampleT cleanOut [numEeg],
  output sampleT eogOut [numRef]
);

  logic    busy;     // frame in flight until the weights move
  logic    stg1Vld;  // R ready
  logic    stg2Vld;  // dot products ready
  sampleT  eegReg [numEeg];
  productT dotNext [numEeg];
  productT dotSum [numEeg];

  assign estReady = !busy && !writerBusy;

  // full-width R times W column, rescaled only once later
  always_comb begin
    for (int j = 0; j < numEeg; j++) begin
      dotNext[j] = '0;
      for (int i = 0; i < numRef; i++)
        dotNext[j] = dotNext[j] + productT'(refVec[i]) * productT'(weights[i][j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      stg1Vld <= 1'b0;
      stg2Vld <= 1'b0;
      estVld  <= 1'b0;
    end else begin
      if (frameVld)
        busy <= 1'b1;
      else if (wUpdated)
        busy <= 1'b0;
      stg1Vld <= frameVld;
      stg2Vld <= stg1Vld;
      estVld  <= stg2Vld;
    end
  end

  //////////////////////////////////////////////////
  // datapath, three stages
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (frameVld) begin
      refVec[0] <= eogIn[0] - eogIn[2]; // eog1 - eog3
      refVec[1] <= eogIn[2] - eogIn[1]; // eog3 - eog2
      refVec[2] <= fixOne;              // bias term
      eegReg    <= eegIn;
      eogOut    <= eogIn;
    end
    if (stg1Vld)
      dotSum <= dotNext;
    if (stg2Vld) begin
      for (int j = 0; j < numEeg; j++)
        cleanOut[j] <= eegReg[j] - rescale(dotSum[j]);
    end
  end

endmodule

// ==== source/fixedDivider.sv ====
// sequential signed Q.35 divider, restoring shift-subtract on magnitudes, 66 cycles
`timescale 1ns/100ps

module fixedDivider import hinfPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   divStart,
  input  sampleT divNum,
  input  sampleT divDen,
  output logic   divDone,
  output sampleT divQuot
);

  typedef enum logic [1:0] {divIdle, divRun, divFix} divStateT;

  divStateT    state;
  logic [5:0]  stepCnt;  // 64 shift-subtract steps
  logic [63:0] numMag;
  logic [63:0] denMag;
  logic [63:0] dMag;     // held divisor magnitude
  logic [63:0] rem;      // partial remainder
  logic [63:0] quo;      // dividend bits out, quotient bits in
  logic [64:0] trial;
  logic        negQ;

  assign numMag = divNum[63] ? 64'(-divNum) : 64'(divNum);
  assign denMag = divDen[63] ? 64'(-divDen) : 64'(divDen);
  assign trial  = {rem, quo[63]} - {1'b0, dMag};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= divIdle;
      stepCnt <= '0;
      divDone <= 1'b0;
    end else begin
      divDone <= 1'b0;
      case (state)
        divIdle: if (divStart) begin
          stepCnt <= '0;
          state   <= divRun;
        end
        divRun: begin
          stepCnt <= stepCnt + 6'd1;
          if (stepCnt == 6'd63)
            state <= divFix;
        end
        divFix: begin
          divDone <= 1'b1;
          state   <= divIdle;
        end
        default: state <= divIdle;
      endcase
    end
  end

  // dividend is |num| << 35, its top bits seed the remainder
  always_ff @(posedge clk) begin
    if (state == divIdle && divStart) begin
      rem  <= numMag >> (64 - fracBits);
      quo  <= numMag << fracBits;
      dMag <= denMag;
      negQ <= divNum[63] ^ divDen[63];
    end else if (state == divRun) begin
      rem <= trial[64] ? {rem[62:0], quo[63]} : trial[63:0]; // restore on borrow
      quo <= {quo[62:0], ~trial[64]};
    end
    if (state == divFix)
      divQuot <= negQ ? -sampleT'(quo) : sampleT'(quo); // truncates toward zero
  end

endmodule

// ==== source/gainCalc.sv ====
// adaptation gain P*R / (1 + R'*P*R) with a frozen diagonal covariance, three divisions
`timescale 1ns/100ps

module gainCalc import hinfPkg::*; #(
  parameter sampleT covDiag = 64'sh28_0000_0000 // 5.0
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   estVld,
  input  sampleT refVec [numRef],
  output logic   gainVld,
  output sampleT gain [numRef]
);

  typedef enum logic [2:0] {gcIdle, gcNum, gcRpr, gcDen, gcIssue, gcWait} gcStateT;

  gcStateT    state;
  logic [1:0] idx;       // division in progress
  sampleT     num [numRef];
  sampleT     terms [numRef];
  sampleT     termSum;
  sampleT     den;
  logic       divStart;
  sampleT     divNum;
  logic       divDone;
  sampleT     divQuot;

  always_comb begin
    termSum = fixOne;
    for (int i = 0; i < numRef; i++)
      termSum = termSum + terms[i];
  end

  fixedDivider div_i (
    .clk, .rst_n, .divStart, .divNum, .divDen(den), .divDone, .divQuot
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= gcIdle;
      idx      <= '0;
      divStart <= 1'b0;
      gainVld  <= 1'b0;
    end else begin
      divStart <= 1'b0;
      gainVld  <= 1'b0;
      case (state)
        gcIdle:  if (estVld) state <= gcNum;
        gcNum:   state <= gcRpr;
        gcRpr:   state <= gcDen;
        gcDen: begin
          idx   <= '0;
          state <= gcIssue;
        end
        gcIssue: begin
          divStart <= 1'b1;
          state    <= gcWait;
        end
        gcWait: begin
          if (divDone) begin
            if (idx == 2'(numRef - 1)) begin
              gainVld <= 1'b1;
              state   <= gcIdle;
            end else begin
              idx   <= idx + 2'd1;
              state <= gcIssue;
            end
          end
        end
        default: state <= gcIdle;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // arithmetic registers
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < numRef; i++) begin
      if (state == gcNum)
        num[i] <= rescale(productT'(covDiag) * productT'(refVec[i])); // P*R
      if (state == gcRpr)
        terms[i] <= rescale(productT'(refVec[i]) * productT'(num[i]));
    end
    if (state == gcDen)
      den <= termSum;
    if (state == gcIssue)
      divNum <= num[idx];
    if (state == gcWait && divDone)
      gain[idx] <= divQuot;
  end

endmodule

// ==== source/weightBank.sv ====
// 3x5 weight matrix, updated by gain times cleaned sample after every frame
`timescale 1ns/100ps

module weightBank import hinfPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   gainVld,
  input  sampleT gain [numRef],
  input  sampleT cleanOut [numEeg],
  output sampleT weights [numRef][numEeg],
  output logic   wUpdated
);

  productT gainProd [numRef][numEeg];
  logic    prodVld; // products registered

  // raw products, one cycle after the gains
  always_ff @(posedge clk) begin
    if (gainVld) begin
      for (int i = 0; i < numRef; i++)
        for (int j = 0; j < numEeg; j++)
          gainProd[i][j] <= productT'(gain[i]) * productT'(cleanOut[j]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prodVld  <= 1'b0;
      wUpdated <= 1'b0;
      for (int i = 0; i < numRef; i++)
        for (int j = 0; j < numEeg; j++)
          weights[i][j] <= '0;
    end else begin
      prodVld  <= gainVld;
      wUpdated <= prodVld;
      if (prodVld) begin
        for (int i = 0; i < numRef; i++)
          for (int j = 0; j < numEeg; j++)
            weights[i][j] <= weights[i][j] + rescale(gainProd[i][j]); // accumulate
      end
    end
  end

endmodule

// ==== source/frameWriter.sv ====
// latches the eight output words and streams them into the transmit FIFO under back-pressure
`timescale 1ns/100ps

module frameWriter import hinfPkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   estVld,
  input  sampleT cleanOut [numEeg],
  input  sampleT eogOut [numRef],
  input  logic   txFull,
  output logic   wr,
  output sampleT dout,
  output logic   done,
  output logic   writerBusy
);

  sampleT     outBuf [frameLen];
  logic [2:0] idx;  // next word to send
  logic       busy;

  assign writerBusy = busy;
  assign wr         = busy && !txFull;   // stall while full
  assign dout       = outBuf[idx];
  assign done       = wr && (idx == 3'(frameLen - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (estVld) begin
      busy <= 1'b1;
      idx  <= '0;
    end else if (wr) begin
      idx <= idx + 3'd1;
      if (idx == 3'(frameLen - 1))
        busy <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (estVld) begin
      for (int j = 0; j < numEeg; j++)
        outBuf[j] <= cleanOut[j];          // cleaned eeg first
      for (int k = 0; k < numRef; k++)
        outBuf[numEeg + k] <= eogOut[k];   // then eog1..eog3
    end
  end

endmodule

// ==== source/hinfTop.sv ====
// top level of the EOG artifact canceller, FIFO-side ports in and out
`timescale 1ns/100ps

module hinfTop import hinfPkg::*; #(
  parameter sampleT covDiag = 64'sh28_0000_0000 // frozen P diagonal, 5.0
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   rxEmpty,
  input  sampleT din,
  output logic   rd,
  input  logic   txFull,
  output logic   wr,
  output sampleT dout,
  output logic   done
);

  //////////////////////////////////////////////////
  // pipeline handshakes and payload
  //////////////////////////////////////////////////
  logic   frameVld, estReady, estVld, gainVld, wUpdated, writerBusy;
  sampleT eegIn [numEeg];
  sampleT eogIn [numRef];
  sampleT refVec [numRef];
  sampleT cleanOut [numEeg];
  sampleT eogOut [numRef];
  sampleT gain [numRef];
  sampleT weights [numRef][numEeg];

  frameReader reader_i (.clk, .rst_n, .rxEmpty, .din, .rd, .estReady, .frameVld, .eegIn, .eogIn);

  artifactEstimator est_i (
    .clk, .rst_n, .frameVld, .eegIn, .eogIn, .weights, .wUpdated, .writerBusy,
    .estReady, .estVld, .refVec, .cleanOut, .eogOut
  );

  gainCalc #(.covDiag(covDiag)) gain_i (.clk, .rst_n, .estVld, .refVec, .gainVld, .gain);

  weightBank wbank_i (.clk, .rst_n, .gainVld, .gain, .cleanOut, .weights, .wUpdated);

  frameWriter writer_i (
    .clk, .rst_n, .estVld, .cleanOut, .eogOut, .txFull, .wr, .dout, .done, .writerBusy
  );

endmodule

// ==== sim/clkGen.sv ====
// testbench clock and reset source, 10 ns period with reset held for 10 cycles
`timescale 1ns/100ps

module clkGen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 10 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// ==== sim/hinfTop_sva.sv ====
// FIFO-side protocol assertions for the canceller top level, attached by bind
`timescale 1ns/100ps

module hinfTop_sva (
  input logic clk,
  input logic rst_n,
  input logic rxEmpty,
  input logic rd,
  input logic txFull,
  input logic wr,
  input logic done
);

  rdNotEmpty: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !rxEmpty)
    else $error("read strobe while the receive FIFO is empty");

  wrNotFull: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !txFull)
    else $error("write strobe while the transmit FIFO is full");

  doneWithWr: assert property (@(posedge clk) disable iff (!rst_n) done |-> wr)
    else $error("done pulse without a write strobe");

endmodule

bind hinfTop hinfTop_sva sva_i (.clk, .rst_n, .rxEmpty, .rd, .txFull, .wr, .done);

// ==== sim/hinfTb.sv ====
// testbench for the canceller: FIFO models, seeded random frames, fixed-point reference model
`timescale 1ns/100ps

module hinfTb
  import hinfPkg::*;
();

  localparam sampleT covDiag       = fixOne * 64'sd5; // 5.0
  localparam int     numFrames     = 20;
  localparam int     totalWords    = numFrames * frameLen;
  localparam int     timeoutCycles = numFrames * 800;
  localparam int     patLen        = 1024; // length of the gap and full patterns

  logic   clk;
  logic   rst_n;
  logic   rxEmpty = 1'b1;
  sampleT din     = '0;
  logic   rd;
  logic   txFull  = 1'b0;
  logic   wr;
  sampleT dout;
  logic   done;

  sampleT inWords [totalWords];  // raw frames, in FIFO order
  sampleT expWords [totalWords]; // model output, in FIFO order
  sampleT rxQ [$];               // receive FIFO contents
  logic   gapPat [patLen];
  logic   fullPat [patLen];
  logic   feedOn    = 1'b0;
  int     cycleCnt  = 0;
  int     outCnt    = 0;
  int     doneCnt   = 0;
  int     rdSeen    = 0;
  int     valErrs   = 0;
  int     otherErrs = 0;

  clkGen clk_i (.clk, .rst_n);

  hinfTop #(.covDiag(covDiag)) dut_i (
    .clk, .rst_n, .rxEmpty, .din, .rd, .txFull, .wr, .dout, .done
  );

  //////////////////////////////////////////////////
  // fixed-point model
  //////////////////////////////////////////////////
  function automatic sampleT randSample();
    logic [63:0] raw;
    raw = {$urandom, $urandom};
    return sampleT'($signed(raw[39:0])); // magnitude below 2^40
  endfunction

  function automatic productT wideMul(input sampleT a, input sampleT b);
    return productT'(a) * productT'(b);
  endfunction

  // arithmetic shift drops the fraction, low 64 bits kept
  function automatic sampleT dropFrac(input productT p);
    productT shifted;
    shifted = p >>> fracBits;
    return sampleT'(shifted[63:0]);
  endfunction

  // magnitude quotient of (n << 35) / d, sign applied afterwards
  function automatic sampleT fixDiv(input sampleT n, input sampleT d);
    logic [63:0]  nAbs;
    logic [63:0]  dAbs;
    logic [127:0] q;
    nAbs = n[63] ? 64'(-n) : 64'(n);
    dAbs = d[63] ? 64'(-d) : 64'(d);
    q = ({64'd0, nAbs} << fracBits) / {64'd0, dAbs};
    return (n[63] ^ d[63]) ? -sampleT'(q[63:0]) : sampleT'(q[63:0]);
  endfunction

  task automatic runModel();
    sampleT  w [numRef][numEeg];
    sampleT  r [numRef];
    sampleT  num [numRef];
    sampleT  clean [numEeg];
    sampleT  g;
    sampleT  den;
    productT acc;
    int      base;
    for (int i = 0; i < numRef; i++)
      for (int j = 0; j < numEeg; j++)
        w[i][j] = '0;
    for (int f = 0; f < numFrames; f++) begin
      base = f * frameLen;
      r[0] = inWords[base + numEeg] - inWords[base + numEeg + 2];     // eog1 - eog3
      r[1] = inWords[base + numEeg + 2] - inWords[base + numEeg + 1]; // eog3 - eog2
      r[2] = fixOne;
      for (int j = 0; j < numEeg; j++) begin
        acc = '0;
        for (int i = 0; i < numRef; i++)
          acc = acc + wideMul(r[i], w[i][j]);
        clean[j] = inWords[base + j] - dropFrac(acc);
        expWords[base + j] = clean[j];
      end
      for (int k = 0; k < numRef; k++)
        expWords[base + numEeg + k] = inWords[base + numEeg + k];
      // gain with the covariance frozen at covDiag * I
      den = fixOne;
      for (int i = 0; i < numRef; i++) begin
        num[i] = dropFrac(wideMul(covDiag, r[i]));
        den    = den + dropFrac(wideMul(r[i], num[i]));
      end
      for (int i = 0; i < numRef; i++) begin
        g = fixDiv(num[i], den);
        for (int j = 0; j < numEeg; j++)
          w[i][j] = w[i][j] + dropFrac(wideMul(g, clean[j]));
      end
    end
  endtask

  task automatic checkSample(input sampleT got, input sampleT exp, input string label);
    if (got !== exp) begin
      $display("Fail %0t: %s, got %h expected %h", $time, label, got, exp);
      valErrs++;
    end
  endtask

  task automatic checkFrame(input int got, input int exp, input string label);
    if (got != exp) begin
      $display("Fail %0t: %s, got %0d expected %0d", $time, label, got, exp);
      valErrs++;
    end
  endtask

  //////////////////////////////////////////////////
  // FIFO models and output monitor
  //////////////////////////////////////////////////
  always @(posedge clk) begin
    cycleCnt++;
    if (!feedOn) begin
      if (rst_n && (rd !== 1'b0 || wr !== 1'b0 || done !== 1'b0)) begin
        $display("at %0t the DUT strobed rd, wr or done while idle", $time);
        otherErrs++;
      end
    end else begin
      if (rd) begin
        rdSeen++;
        if (rxQ.size() == 0) begin
          $display("at %0t the DUT read from an empty receive FIFO", $time);
          otherErrs++;
        end else begin
          din <= rxQ.pop_front(); // visible next cycle
        end
      end
      rxEmpty <= (rxQ.size() == 0) || gapPat[cycleCnt % patLen];
      txFull  <= fullPat[cycleCnt % patLen];
      if (wr) begin
        if (outCnt >= totalWords) begin
          $display("at %0t the DUT wrote more words than were sent", $time);
          otherErrs++;
        end else begin
          checkSample(dout, expWords[outCnt], "output word");
          if (outCnt < frameLen)
            checkSample(dout, inWords[outCnt], "first frame passthrough");
          if (done !== ((outCnt % frameLen) == frameLen - 1)) begin
            $display("at %0t done is not aligned with the eighth word of a frame", $time);
            otherErrs++;
          end
        end
        if (done)
          doneCnt++;
        outCnt++;
      end else if (done) begin
        $display("at %0t done pulsed without a write", $time);
        otherErrs++;
      end
    end
  end

  initial begin
    void'($urandom(32'h0382_8922));
    for (int n = 0; n < totalWords; n++) begin
      inWords[n] = randSample();
      rxQ.push_back(inWords[n]);
    end
    for (int k = 0; k < patLen; k++) begin
      gapPat[k]  = ($urandom_range(4, 0) == 0);
      fullPat[k] = ($urandom_range(3, 0) == 0);
    end
    runModel();
    @(posedge rst_n);
    repeat (20) @(posedge clk); // idle with rxEmpty high
    feedOn <= 1'b1;
    while (outCnt < totalWords && cycleCnt < timeoutCycles)
      @(posedge clk);
    if (outCnt < totalWords) begin
      $display("timeout after %0d cycles, %0d of %0d words written", cycleCnt, outCnt,
               totalWords);
      otherErrs++;
    end
    repeat (20) @(posedge clk); // catch stray writes
    checkFrame(doneCnt, numFrames, "done pulses");
    checkFrame(rdSeen, totalWords, "words read");
    checkFrame(outCnt, totalWords, "words written");
    $display("errors: %0d value mismatches, %0d other failures", valErrs, otherErrs);
    if (valErrs + otherErrs == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

// ==== list.f ====
source/hinfPkg.sv
source/frameReader.sv
source/artifactEstimator.sv
source/fixedDivider.sv
source/gainCalc.sv
source/weightBank.sv
source/frameWriter.sv
source/hinfTop.sv
sim/clkGen.sv
sim/hinfTop_sva.sv
sim/hinfTb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := hinfTb
FILELIST  := list.f
OBJDIR    := obj_dir
SIMBIN    := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
